// ==== logic/cmdp_defines.svh ====
`ifndef CMDP_DEFINES_SVH
`define CMDP_DEFINES_SVH

// Command buffer geometry.
`define CMDP_BUF_DEPTH 256  // Words in the command buffer.
`define CMDP_ADDR_W    8    // Buffer address width.

// Working register file.
`define CMDP_NUM_REGS  8    // Registers addressed by arg1 and arg2.

`endif

// ==== logic/cmdp_pkg.sv ====
`include "cmdp_defines.svh"

package cmdp_pkg;

	// Command opcodes. Values not listed are illegal.
	typedef enum logic [7:0] {
		LDI  = 8'h01,  // Load arg2 into register arg1.
		ADD  = 8'h02,
		SUB  = 8'h03,
		XOR  = 8'h04,
		SHL  = 8'h05,
		HALT = 8'hFF   // Ends the run.
	} opcode_e;

	typedef enum logic [1:0] {F_IDLE, F_READ, F_SPLIT, F_DONE} fetch_state_e;

	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_EXEC, S_STOP} seq_state_e;

	// One command word as stored in the buffer.
	typedef struct packed {
		opcode_e    instr;
		logic [2:0] arg1;  // Destination register.
		logic [4:0] arg2;  // Source register or immediate.
	} cmd_t;

	localparam cmd_t CMD_RESET = '{instr: HALT, arg1: 3'd0, arg2: 5'd0};

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic                    busy;
		logic                    halted;
		logic                    illegal;
		logic [7:0]              exec_cnt;  // Commands run, wraps at 256.
		logic [`CMDP_ADDR_W-1:0] stop_addr;
	} status_t;

endpackage

// ==== logic/cmd_buffer.sv ====
`timescale 1ns/1ps
`include "cmdp_defines.svh"

module cmd_buffer (
	input  logic                    clk,
	input  logic                    wr_en,
	input  logic [`CMDP_ADDR_W-1:0] wr_addr,
	input  logic [15:0]             wr_data,
	input  logic                    rd_en,
	input  logic [`CMDP_ADDR_W-1:0] rd_addr,
	output cmdp_pkg::cmd_t          rd_data
);

	import cmdp_pkg::*;

	logic [15:0] mem [`CMDP_BUF_DEPTH];  // Command words.

	// Host side write port.
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Fetch side read port, word valid one cycle after rd_en.
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= cmd_t'(mem[rd_addr]);
		end
	end

endmodule

// ==== logic/cmd_fetch.sv ====
`timescale 1ns/1ps
`include "cmdp_defines.svh"

module cmd_fetch (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    load_ptr,
	input  logic [`CMDP_ADDR_W-1:0] start_addr,
	input  logic                    fetch_start,
	input  cmdp_pkg::cmd_t          rd_data,
	output logic                    rd_en,
	output logic [`CMDP_ADDR_W-1:0] rd_addr,
	output cmdp_pkg::cmd_t          cmd,
	output logic                    fetch_done
);

	import cmdp_pkg::*;

	fetch_state_e            state;
	fetch_state_e            next_state;
	logic [`CMDP_ADDR_W-1:0] ptr;  // Address of the next command.

	assign rd_en      = (state == F_READ);
	assign rd_addr    = ptr;
	assign fetch_done = (state == F_DONE);  // Three cycles after start.

	always_comb
	begin
		next_state = state;
		case (state)
			F_IDLE:
			begin
				if (fetch_start)
				begin
					next_state = F_READ;
				end
			end
			F_READ:  next_state = F_SPLIT;  // Buffer read in flight.
			F_SPLIT: next_state = F_DONE;
			F_DONE:  next_state = F_IDLE;
			default: next_state = F_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= F_IDLE;
			ptr   <= '0;
			cmd   <= CMD_RESET;
		end
		else if (load_ptr)
		begin
			// A new run restarts from the host's address.
			state <= F_IDLE;
			ptr   <= start_addr;
			cmd   <= CMD_RESET;
		end
		else
		begin
			state <= next_state;
			if (state == F_SPLIT)
			begin
				cmd.instr <= rd_data.instr;  // Split word into fields.
				cmd.arg1  <= rd_data.arg1;
				cmd.arg2  <= rd_data.arg2;
				ptr       <= ptr + 1'b1;     // Wraps at buffer end.
			end
		end
	end

endmodule

// ==== logic/cmd_exec.sv ====
`timescale 1ns/1ps
`include "cmdp_defines.svh"

module cmd_exec (
	input  logic           clk,
	input  logic           rst,
	input  logic           clear,
	input  logic           exec_en,
	input  cmdp_pkg::cmd_t cmd,
	input  logic [2:0]     rd_idx,
	output logic [15:0]    rd_val,
	output logic           halt,
	output logic           illegal
);

	import cmdp_pkg::*;

	logic [15:0] regs [`CMDP_NUM_REGS];  // Working registers.
	logic [15:0] dst_val;
	logic [15:0] src_val;
	logic [15:0] result;
	logic        wr;                      // Opcode writes a register.

	assign dst_val = regs[cmd.arg1];
	assign src_val = regs[cmd.arg2[2:0]];
	assign rd_val  = regs[rd_idx];         // Host readback.

	// Opcode decode and ALU.
	always_comb
	begin
		result  = dst_val;
		wr      = 1'b0;
		halt    = 1'b0;
		illegal = 1'b0;
		case (cmd.instr)
			LDI:
			begin
				result = {11'd0, cmd.arg2};
				wr     = 1'b1;
			end
			ADD:
			begin
				result = dst_val + src_val;  // Wraps at 16 bits.
				wr     = 1'b1;
			end
			SUB:
			begin
				result = dst_val - src_val;
				wr     = 1'b1;
			end
			XOR:
			begin
				result = dst_val ^ src_val;
				wr     = 1'b1;
			end
			SHL:
			begin
				result = dst_val << cmd.arg2[3:0];
				wr     = 1'b1;
			end
			HALT:    halt    = exec_en;
			default: illegal = exec_en;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < `CMDP_NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (clear)
		begin
			for (int i = 0; i < `CMDP_NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (exec_en && wr)
		begin
			regs[cmd.arg1] <= result;  // Visible the next cycle.
		end
	end

endmodule

// ==== logic/cmd_sequencer.sv ====
`timescale 1ns/1ps
`include "cmdp_defines.svh"

module cmd_sequencer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic [`CMDP_ADDR_W-1:0] start_addr,
	input  logic                    fetch_done,
	input  logic                    halt,
	input  logic                    illegal,
	input  logic [`CMDP_ADDR_W-1:0] rd_addr,
	output logic                    load_ptr,
	output logic                    clear,
	output logic                    fetch_start,
	output logic                    exec_en,
	output cmdp_pkg::status_t       status
);

	import cmdp_pkg::*;

	seq_state_e state;
	seq_state_e next_state;
	logic       run_start;  // Start accepted.
	logic       run_stop;   // Last command of the run.

	assign run_start = start && ((state == S_IDLE) || (state == S_STOP));
	assign run_stop  = (state == S_EXEC) && (halt || illegal);
	assign load_ptr  = run_start;
	assign clear     = run_start;
	assign exec_en   = (state == S_EXEC);  // One cycle per command.

	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE, S_STOP:
			begin
				if (start)
				begin
					next_state = S_FETCH;
				end
			end
			S_FETCH:
			begin
				if (fetch_done)
				begin
					next_state = S_EXEC;
				end
			end
			S_EXEC:  next_state = run_stop ? S_STOP : S_FETCH;
			default: next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state       <= S_IDLE;
			fetch_start <= 1'b0;
			status      <= '0;
		end
		else
		begin
			state       <= next_state;
			fetch_start <= run_start || ((state == S_EXEC) && !run_stop);
			if (run_start)
			begin
				status.busy      <= 1'b1;
				status.halted    <= 1'b0;
				status.illegal   <= 1'b0;
				status.exec_cnt  <= '0;
				status.stop_addr <= start_addr;  // Until the run ends.
			end
			else if (state == S_EXEC)
			begin
				status.exec_cnt <= status.exec_cnt + 1'b1;  // Counts the stopper too.
				if (run_stop)
				begin
					status.busy      <= 1'b0;
					status.halted    <= halt;
					status.illegal   <= illegal;
					status.stop_addr <= rd_addr - 1'b1;  // Pointer already advanced.
				end
			end
		end
	end

endmodule

// ==== logic/apb_regs.sv ====
`timescale 1ns/1ps
`include "cmdp_defines.svh"

module apb_regs (
	input  logic                    clk,
	input  logic                    rst,
	input  cmdp_pkg::apb_req_t      apb_req,
	output cmdp_pkg::apb_rsp_t      apb_rsp,
	input  cmdp_pkg::status_t       status,
	input  logic [15:0]             rd_val,
	output logic [2:0]              rd_idx,
	output logic                    wr_en,
	output logic [`CMDP_ADDR_W-1:0] wr_addr,
	output logic [15:0]             wr_data,
	output logic                    start,
	output logic [`CMDP_ADDR_W-1:0] start_addr
);

	import cmdp_pkg::*;

	logic        setup;
	logic        access;
	logic        wr_acc;    // Write in the access phase.
	logic        ctrl_sel;
	logic        stat_sel;
	logic        reg_sel;   // 0x100 register window.
	logic        buf_sel;   // 0x400 buffer window.
	logic [31:0] rd_mux;
	logic [31:0] prdata_q;

	assign setup    = apb_req.psel && !apb_req.penable;
	assign access   = apb_req.psel && apb_req.penable;
	assign wr_acc   = access && apb_req.pwrite;
	assign ctrl_sel = (apb_req.paddr == 12'h000);
	assign stat_sel = (apb_req.paddr == 12'h004);
	assign reg_sel  = (apb_req.paddr[11:5] == 7'h08) && (apb_req.paddr[1:0] == 2'b00);
	assign buf_sel  = (apb_req.paddr[11:10] == 2'b01) && (apb_req.paddr[1:0] == 2'b00);

	assign rd_idx     = apb_req.paddr[4:2];
	assign wr_addr    = apb_req.paddr[`CMDP_ADDR_W+1:2];
	assign wr_data    = apb_req.pwdata[15:0];
	assign wr_en      = wr_acc && buf_sel && !status.busy;
	assign start      = wr_acc && ctrl_sel && apb_req.pwdata[8] && !status.busy;
	assign start_addr = apb_req.pwdata[`CMDP_ADDR_W-1:0];

	always_comb
	begin
		rd_mux = '0;
		if (stat_sel)
		begin
			rd_mux[0]                   = status.busy;
			rd_mux[1]                   = status.halted;
			rd_mux[2]                   = status.illegal;
			rd_mux[15:8]                = status.exec_cnt;
			rd_mux[16 +: `CMDP_ADDR_W] = status.stop_addr;
		end
		else if (reg_sel)
		begin
			rd_mux[15:0] = rd_val;
		end
	end

	// Read data captured in setup, held through access.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			prdata_q <= '0;
		end
		else if (setup && !apb_req.pwrite)
		begin
			prdata_q <= rd_mux;
		end
	end

	assign apb_rsp.prdata  = prdata_q;
	assign apb_rsp.pready  = 1'b1;  // No wait states.
	assign apb_rsp.pslverr = access && (!(ctrl_sel || stat_sel || reg_sel || buf_sel)
		|| (apb_req.pwrite && (stat_sel || reg_sel))
		|| (apb_req.pwrite && buf_sel && status.busy));

endmodule

// ==== logic/cmdp_top.sv ====
`timescale 1ns/1ps
`include "cmdp_defines.svh"

module cmdp_top (
	input  logic               clk,
	input  logic               rst,
	input  cmdp_pkg::apb_req_t apb_req,
	output cmdp_pkg::apb_rsp_t apb_rsp
);

	import cmdp_pkg::*;

	logic                    wr_en;
	logic [`CMDP_ADDR_W-1:0] wr_addr;
	logic [15:0]             wr_data;
	logic                    rd_en;
	logic [`CMDP_ADDR_W-1:0] rd_addr;
	cmd_t                    rd_data;
	cmd_t                    cmd;       // Current decoded command.
	logic                    start;
	logic [`CMDP_ADDR_W-1:0] start_addr;
	logic                    load_ptr;
	logic                    clear;
	logic                    fetch_start;
	logic                    fetch_done;
	logic                    exec_en;
	logic                    halt;
	logic                    illegal;
	status_t                 status;
	logic [2:0]              rd_idx;
	logic [15:0]             rd_val;

	apb_regs i_apb_regs (
		.clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.status(status), .rd_val(rd_val), .rd_idx(rd_idx),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.start(start), .start_addr(start_addr)
	);

	cmd_buffer i_cmd_buffer (
		.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	cmd_fetch i_cmd_fetch (
		.clk(clk), .rst(rst), .load_ptr(load_ptr), .start_addr(start_addr),
		.fetch_start(fetch_start), .rd_data(rd_data), .rd_en(rd_en),
		.rd_addr(rd_addr), .cmd(cmd), .fetch_done(fetch_done)
	);

	cmd_exec i_cmd_exec (
		.clk(clk), .rst(rst), .clear(clear), .exec_en(exec_en), .cmd(cmd),
		.rd_idx(rd_idx), .rd_val(rd_val), .halt(halt), .illegal(illegal)
	);

	cmd_sequencer i_cmd_sequencer (
		.clk(clk), .rst(rst), .start(start), .start_addr(start_addr),
		.fetch_done(fetch_done), .halt(halt), .illegal(illegal), .rd_addr(rd_addr),
		.load_ptr(load_ptr), .clear(clear), .fetch_start(fetch_start),
		.exec_en(exec_en), .status(status)
	);

endmodule

// ==== dv/cmdp_checker.sv ====
`timescale 1ns/1ps

module cmdp_checker (
	input logic               clk,
	input logic               rst,
	input logic               fetch_start,
	input logic               fetch_done,
	input logic               exec_en,
	input cmdp_pkg::apb_req_t apb_req,
	input cmdp_pkg::apb_rsp_t apb_rsp
);

	import cmdp_pkg::*;

	int fail_count = 0;  // Assertion failures so far.

	// Fetch latency is fixed at three cycles.
	fetch_latency: assert property (@(posedge clk) disable iff (!rst)
		fetch_start |-> ##3 fetch_done)
		else
		begin
			$error("fetch_done did not follow fetch_start by 3 cycles");
			fail_count++;
		end

	// Execute only with a freshly fetched command.
	exec_after_fetch: assert property (@(posedge clk) disable iff (!rst)
		exec_en |-> $past(fetch_done))
		else
		begin
			$error("exec_en without a preceding fetch_done");
			fail_count++;
		end

	apb_no_wait: assert property (@(posedge clk) disable iff (!rst)
		apb_req.psel |-> apb_rsp.pready)
		else
		begin
			$error("PREADY low while PSEL high");
			fail_count++;
		end

endmodule

bind cmdp_top cmdp_checker i_checker (
	.clk(clk), .rst(rst), .fetch_start(fetch_start), .fetch_done(fetch_done),
	.exec_en(exec_en), .apb_req(apb_req), .apb_rsp(apb_rsp)
);

// ==== dv/cmdp_tb.sv ====
`timescale 1ns/1ps

module cmdp_tb;

	import cmdp_pkg::*;

	logic        clk;
	logic        rst;
	apb_req_t    req;
	apb_rsp_t    rsp;
	integer      seed = 70;
	integer      errors = 0;
	integer      tests_run = 0;
	integer      tests_failed = 0;
	integer      err_mark;
	logic [15:0] prog [256];  // Host copy of the buffer.
	logic [15:0] m_regs [8];   // Model register file.
	logic [7:0]  m_cnt;
	logic [7:0]  m_stop;
	logic        m_halt;
	logic        m_ill;
	logic        err;
	logic [31:0] rdata;
	logic [7:0]  saddr;

	cmdp_top i_dut (.clk(clk), .rst(rst), .apb_req(req), .apb_rsp(rsp));

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic e);
		req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clk);
		#5 req.penable = 1'b1;
		@(negedge clk);
		e = rsp.pslverr;  // Sampled mid access phase.
		@(posedge clk);
		#5 req = '0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic e);
		req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(posedge clk);
		#5 req.penable = 1'b1;
		@(negedge clk);
		data = rsp.prdata;
		e    = rsp.pslverr;
		@(posedge clk);
		#5 req = '0;
	endtask

	task automatic expect_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Poll STATUS until the run ends.
	task automatic wait_idle();
		logic [31:0] st;
		logic        e;
		int          n;
		n  = 0;
		st = 32'd1;
		while ((st[0] === 1'b1 || st[0] === 1'bx) && n <= 500)
		begin
			apb_read(12'h004, st, e);
			n++;
		end
		if (st[0] !== 1'b0)
		begin
			$display("Timeout waiting for the run to finish");
			$display(">>> FAIL");
			$finish;
		end
	endtask

	// Random legal commands, optional illegal one at bad_pos, then HALT.
	task automatic gen_program(input logic [7:0] start, input int len, input int bad_pos);
		logic [7:0] a;
		logic [7:0] op;
		a = start;
		for (int i = 0; i < len; i++)
		begin
			op = 8'd1 + 8'($unsigned($random(seed)) % 5);
			if (i == bad_pos)
			begin
				op = 8'h40 | 8'($random(seed) & 8'h3F);  // Never a legal opcode.
			end
			prog[a] = {op, 8'($random(seed))};
			a++;
		end
		prog[a] = 16'hFF00;
	endtask

	task automatic load_words(input logic [7:0] first, input int count);
		logic [7:0] a;
		logic       e;
		a = first;
		for (int i = 0; i < count; i++)
		begin
			apb_write(12'h400 + {a, 2'b00}, {16'd0, prog[a]}, e);
			expect_val(e, 0, "PSLVERR on buffer write");
			a++;
		end
	endtask

	task automatic run_model(input logic [7:0] start);
		logic [7:0]  pc;
		logic [15:0] w;
		logic [2:0]  d;
		pc = start;
		m_cnt = 0;
		m_halt = 0;
		m_ill = 0;
		for (int i = 0; i < 8; i++)
		begin
			m_regs[i] = 16'd0;
		end
		while (!m_halt && !m_ill)
		begin
			w = prog[pc];
			d = w[7:5];
			m_cnt++;
			case (w[15:8])
				8'h01: m_regs[d] = {11'd0, w[4:0]};
				8'h02: m_regs[d] = m_regs[d] + m_regs[w[2:0]];
				8'h03: m_regs[d] = m_regs[d] - m_regs[w[2:0]];
				8'h04: m_regs[d] = m_regs[d] ^ m_regs[w[2:0]];
				8'h05: m_regs[d] = m_regs[d] << w[3:0];
				8'hFF: m_halt = 1'b1;
				default: m_ill = 1'b1;
			endcase
			m_stop = pc;
			pc++;
		end
	endtask

	task automatic run_and_check(input logic [7:0] start);
		logic [31:0] d;
		logic        e;
		apb_write(12'h000, 32'h100 | start, e);
		expect_val(e, 0, "PSLVERR on CTRL write");
		wait_idle();
		run_model(start);
		apb_read(12'h004, d, e);
		expect_val(d, {8'd0, m_stop, m_cnt, 5'd0, m_ill, m_halt, 1'b0}, "STATUS");
		expect_val(e, 0, "PSLVERR on STATUS read");
		for (int i = 0; i < 8; i++)
		begin
			apb_read(12'h100 + 4 * i, d, e);
			expect_val(d, {16'd0, m_regs[i]}, $sformatf("register %0d", i));
			expect_val(e, 0, "PSLVERR on register read");
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark)
		begin
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
		err_mark = errors;
	endtask

	initial
	begin
		req = '0;
		rst = 1'b0;
		err_mark = 0;
		repeat (2) @(posedge clk);
		#5 rst = 1'b1;

		apb_read(12'h004, rdata, err);
		expect_val(rdata, 0, "STATUS after reset");
		for (int i = 0; i < 8; i++)
		begin
			apb_read(12'h100 + 4 * i, rdata, err);
			expect_val(rdata, 0, "register after reset");
		end
		end_test("1 reset values");

		for (int p = 0; p < 5; p++)
		begin
			gen_program(8'd0, 6 + p * 3, -1);
			load_words(8'd0, 7 + p * 3);
			run_and_check(8'd0);
		end
		end_test("2 programs at address 0");

		saddr = 8'd10 + 8'($unsigned($random(seed)) % 200);
		for (int i = 1; i <= 8; i++)
		begin
			prog[saddr - i] = {8'h01, 8'($random(seed))};  // Must not run.
		end
		gen_program(saddr, 10, -1);
		load_words(saddr - 8'd8, 19);
		run_and_check(saddr);
		end_test("3 nonzero start address");

		gen_program(8'd60, 12, 2 + $unsigned($random(seed)) % 8);
		load_words(8'd60, 13);
		run_and_check(8'd60);
		end_test("4 illegal opcode");

		gen_program(8'h20, 15, -1);
		load_words(8'h20, 16);
		run_and_check(8'h20);
		apb_write(12'h000, 32'h120, err);
		apb_write(12'h480, 32'h0000_0107, err);  // Overwrite first word mid run.
		expect_val(err, 1, "PSLVERR on buffer write while busy");
		wait_idle();
		run_and_check(8'h20);
		apb_read(12'h008, rdata, err);
		expect_val(err, 1, "PSLVERR on unmapped read");
		apb_write(12'h004, 32'd0, err);
		expect_val(err, 1, "PSLVERR on STATUS write");
		apb_write(12'h108, 32'd0, err);
		expect_val(err, 1, "PSLVERR on register write");
		apb_read(12'h800, rdata, err);
		expect_val(err, 1, "PSLVERR on high unmapped read");
		end_test("5 slave errors");

		$display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, i_dut.i_checker.fail_count);
		if (errors == 0 && i_dut.i_checker.fail_count == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/cmdp_pkg.sv
logic/cmd_buffer.sv
logic/cmd_fetch.sv
logic/cmd_exec.sv
logic/cmd_sequencer.sv
logic/apb_regs.sv
logic/cmdp_top.sv
dv/cmdp_checker.sv
dv/cmdp_tb.sv
